// ==== vlog.f ====
+incdir+src
src/cache_pkg.sv
src/mem_pkg.sv
src/line_sram.sv
src/line_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_dcache
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_dcache.sv ====
// data cache testbench
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tb_dcache;

    localparam int REQ_LIMIT   = 200;
    localparam int RESP_LIMIT  = 400;
    localparam int FENCE_LIMIT = `CACHE_NLINE * 40;

    logic                 clk;
    logic                 rst;
    logic                 cpu_req_valid;
    logic                 cpu_req_ready;
    cache_pkg::cpu_req_t  cpu_req;
    logic                 cpu_resp_valid;
    cache_pkg::cpu_resp_t cpu_resp;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    mem_pkg::mem_req_t    mem_req;
    logic                 mem_resp_valid;
    mem_pkg::mem_resp_t   mem_resp;
    logic                 expect_hit;
    int                   err_count;
    int                   check_count;
    int                   tests;
    int                   failed_tests;
    int                   err_mark;

    logic [127:0] line_mem [logic [59:0]]; // sparse backing memory

    dcache_top u_dcache_top (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_valid_i  (cpu_req_valid),
        .cpu_req_ready_o  (cpu_req_ready),
        .cpu_req_i        (cpu_req),
        .cpu_resp_valid_o (cpu_resp_valid),
        .cpu_resp_o       (cpu_resp),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_o        (mem_req),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_i       (mem_resp)
    );

    dcache_checker u_checker (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_valid_i  (cpu_req_valid),
        .cpu_req_ready_i  (cpu_req_ready),
        .cpu_req_i        (cpu_req),
        .cpu_resp_valid_i (cpu_resp_valid),
        .cpu_resp_i       (cpu_resp),
        .mem_req_valid_i  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_i        (mem_req),
        .expect_hit_i     (expect_hit),
        .err_count_o      (err_count),
        .check_count_o    (check_count)
    );

    function automatic logic [63:0] dw_pat(input logic [63:0] a);
        return {a[31:0] ^ 32'h3c5a_9e17, a[63:32] ^ ~a[31:0]};
    endfunction

    function automatic logic [127:0] line_get(input logic [59:0] k);
        return line_mem.exists(k) ? line_mem[k] : {dw_pat({k, 4'h8}), dw_pat({k, 4'h0})};
    endfunction

    // small tag set keeps conflicts frequent
    function automatic logic [63:0] rand_addr(input int tag_sel, input int idx);
        cache_pkg::addr_u a;
        a.f.tag    = cache_pkg::TAG_W'(tag_sel * 32'h0001_0003 + 5);
        a.f.index  = cache_pkg::INDEX_W'(idx);
        a.f.offset = {$urandom_range(0, 1) == 1, 3'b000};
        return a.raw;
    endfunction

    task automatic timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display(">>> FAIL");
        $finish;
    endtask

    // starts on a falling edge and returns on the falling edge of the response
    task automatic send_req(input cache_pkg::cpu_op_e op, input logic [63:0] addr,
                            input logic hit, input int resp_limit);
        int n;
        cpu_req.op       = op;
        cpu_req.addr.raw = addr;
        cpu_req.wdata    = {$urandom, $urandom};
        cpu_req.wmask    = 8'($urandom);
        cpu_req_valid    = 1'b1;
        expect_hit       = hit;
        n = 0;
        while (!cpu_req_ready) begin
            @(negedge clk);
            n++;
            if (n > REQ_LIMIT) timeout("CPU request ready");
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;
        expect_hit    = 1'b0;
        n = 0;
        while (!cpu_resp_valid) begin
            @(negedge clk);
            n++;
            if (n > resp_limit) timeout("CPU response");
        end
    endtask

    task automatic end_test(input string name);
        send_req(cache_pkg::OP_FENCE, 64'h0, 1'b0, FENCE_LIMIT);
        @(negedge clk); // checker takes the fence response on the rising edge
        tests++;
        if (err_count != err_mark) failed_tests++;
        $display("test %s: %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory responder with random ready and 1 to 8 cycle latency
    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        forever begin
            @(negedge clk);
            mem_resp_valid = 1'b0;
            mem_req_ready  = ($urandom_range(0, 2) != 0);
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.write) begin
                    line_mem[mem_req.addr[63:4]] = mem_req.wline;
                end else begin
                    mem_resp.rline = line_get(mem_req.addr[63:4]);
                end
                @(negedge clk);
                mem_req_ready = 1'b0;
                repeat ($urandom_range(1, 8) - 1) @(negedge clk);
                mem_resp_valid = 1'b1;
            end
        end
    end

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        int          idx;
        void'($urandom(38607));
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        expect_hit    = 1'b0;
        tests         = 0;
        failed_tests  = 0;
        err_mark      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < 40; i++) begin
            send_req(cache_pkg::OP_LOAD, rand_addr($urandom_range(0, 3), $urandom_range(0, 255)),
                     1'b0, RESP_LIMIT);
        end
        end_test("first_loads");

        for (int i = 0; i < 40; i++) begin
            a = rand_addr($urandom_range(0, 3), $urandom_range(0, 255));
            send_req(cache_pkg::OP_STORE, a, 1'b0, RESP_LIMIT);
            send_req(cache_pkg::OP_LOAD, a, 1'b1, RESP_LIMIT);
        end
        end_test("store_load");

        for (int i = 0; i < 30; i++) begin
            idx = $urandom_range(0, 255);
            a   = rand_addr(0, idx);
            b   = rand_addr($urandom_range(1, 3), idx);
            send_req(cache_pkg::OP_STORE, a, 1'b0, RESP_LIMIT);
            send_req(cache_pkg::OP_STORE, b, 1'b0, RESP_LIMIT);
            send_req(cache_pkg::OP_LOAD, a, 1'b0, RESP_LIMIT);
        end
        end_test("evict");

        for (int i = 0; i < 30; i++) begin
            a = rand_addr($urandom_range(0, 3), $urandom_range(0, 255));
            send_req(cache_pkg::OP_LOAD, a, 1'b0, RESP_LIMIT);
            send_req(cache_pkg::OP_LOAD, a, 1'b1, RESP_LIMIT);
        end
        end_test("hit_latency");

        for (int i = 0; i < 300; i++) begin
            a = rand_addr($urandom_range(0, 3), $urandom_range(0, 15)); // few indices
            if ($urandom_range(0, 1) == 1) begin
                send_req(cache_pkg::OP_STORE, a, 1'b0, RESP_LIMIT);
            end else begin
                send_req(cache_pkg::OP_LOAD, a, 1'b0, RESP_LIMIT);
            end
        end
        end_test("random_mix");

        repeat (4) @(negedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, check_count, err_count);
        if (err_count == 0 && failed_tests == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/dcache_checker.sv ====
// data cache port checker
`timescale 1ns/10ps

module dcache_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req_valid_i,
    input  logic                 cpu_req_ready_i,
    input  cache_pkg::cpu_req_t  cpu_req_i,
    input  logic                 cpu_resp_valid_i,
    input  cache_pkg::cpu_resp_t cpu_resp_i,
    input  logic                 mem_req_valid_i,
    input  logic                 mem_req_ready_i,
    input  mem_pkg::mem_req_t    mem_req_i,
    input  logic                 expect_hit_i,
    output int                   err_count_o,
    output int                   check_count_o
);

    logic [63:0] ref_mem [logic [60:0]];     // doubleword address keyed
    logic [63:0] obs_mem [logic [60:0]];     // what memory has received
    bit          stored_line [logic [59:0]];

    cache_pkg::cpu_req_t cur_req;
    mem_pkg::mem_req_t   hold_req;
    logic [63:0]         exp_data;
    logic                outstanding;
    logic                hit_flag;
    logic                hold_valid;
    logic                rst_q;
    int                  cycle;
    int                  acc_cycle;
    int                  errs;
    int                  checks;

    assign err_count_o   = errs;
    assign check_count_o = checks;

    function automatic logic [63:0] dw_pat(input logic [63:0] a);
        return {a[31:0] ^ 32'h3c5a_9e17, a[63:32] ^ ~a[31:0]};
    endfunction

    function automatic logic [63:0] ref_get(input logic [60:0] k);
        return ref_mem.exists(k) ? ref_mem[k] : dw_pat({k, 3'b000});
    endfunction

    function automatic logic [63:0] obs_get(input logic [60:0] k);
        return obs_mem.exists(k) ? obs_mem[k] : dw_pat({k, 3'b000});
    endfunction

    task automatic report(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errs++;
    endtask

    task automatic check_write();
        logic [59:0] key;
        logic [63:0] half;
        key = mem_req_i.addr[63:4];
        checks++;
        if (outstanding && cur_req.op == cache_pkg::OP_FENCE && !stored_line.exists(key)) begin
            report($sformatf("fence wrote line 0x%0h that was never stored", key));
        end
        for (int h = 0; h < 2; h++) begin
            half = mem_req_i.wline[h*64 +: 64];
            if (half !== ref_get({key, h[0]})) begin
                report($sformatf("write-back 0x%0h half %0d got %h exp %h",
                                 mem_req_i.addr, h, half, ref_get({key, h[0]})));
            end
            obs_mem[{key, h[0]}] = half;
        end
    endtask

    task automatic check_resp();
        checks++;
        if (!outstanding) begin
            report("response pulse without an open request");
        end else begin
            outstanding = 1'b0;
            if (cpu_resp_i.op != cur_req.op) begin
                report($sformatf("response op %0d for request op %0d", cpu_resp_i.op, cur_req.op));
            end
            if (cur_req.op == cache_pkg::OP_LOAD) begin
                if (cpu_resp_i.rdata !== exp_data) begin
                    report($sformatf("load 0x%0h got %h exp %h",
                                     cur_req.addr.raw, cpu_resp_i.rdata, exp_data));
                end
                if (hit_flag && (cycle - acc_cycle) != 3) begin
                    report($sformatf("hit latency %0d cycles", cycle - acc_cycle));
                end
            end
            if (cur_req.op == cache_pkg::OP_FENCE) begin
                foreach (ref_mem[k]) begin
                    if (obs_get(k) !== ref_mem[k]) begin
                        report($sformatf("after fence memory 0x%0h holds %h exp %h",
                                         {k, 3'b000}, obs_get(k), ref_mem[k]));
                    end
                end
            end
        end
    endtask

    task automatic accept();
        logic [60:0] k;
        k = cpu_req_i.addr.raw[63:3];
        if (cpu_req_i.op == cache_pkg::OP_STORE) begin
            ref_mem[k] = ref_get(k);
            for (int i = 0; i < 8; i++) begin
                if (cpu_req_i.wmask[i]) ref_mem[k][i*8 +: 8] = cpu_req_i.wdata[i*8 +: 8];
            end
            stored_line[k[60:1]] = 1'b1;
        end
        exp_data    = ref_get(k); // only used by loads
        cur_req     = cpu_req_i;
        hit_flag    = expect_hit_i;
        acc_cycle   = cycle;
        outstanding = 1'b1;
    endtask

    initial begin
        errs        = 0;
        checks      = 0;
        cycle       = 0;
        outstanding = 1'b0;
        hold_valid  = 1'b0;
        rst_q       = 1'b0;
    end

    always @(posedge clk) begin
        cycle++;
        if (rst) begin
            outstanding = 1'b0;
            hold_valid  = 1'b0;
            rst_q       = 1'b1;
        end else begin
            if (rst_q && (!cpu_req_ready_i || mem_req_valid_i || cpu_resp_valid_i)) begin
                report("port state after reset is wrong");
            end
            rst_q = 1'b0;
            if (hold_valid && (!mem_req_valid_i || mem_req_i !== hold_req)) begin
                report("memory request changed while waiting for ready");
            end
            hold_valid = mem_req_valid_i && !mem_req_ready_i;
            hold_req   = mem_req_i;
            if (mem_req_valid_i && mem_req_ready_i && mem_req_i.write) check_write();
            if (cpu_resp_valid_i) check_resp();
            if (outstanding && cpu_req_ready_i) report("ready high while a request is open");
            if (cpu_req_valid_i && cpu_req_ready_i) accept();
        end
    end

endmodule

// ==== src/dcache_top.sv ====
// data cache top level
`timescale 1ns/10ps
`include "cache_cfg.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    // CPU port
    input  logic                 cpu_req_valid_i,
    output logic                 cpu_req_ready_o,
    input  cache_pkg::cpu_req_t  cpu_req_i,
    output logic                 cpu_resp_valid_o,
    output cache_pkg::cpu_resp_t cpu_resp_o,
    // memory port
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output mem_pkg::mem_req_t    mem_req_o,
    input  logic                 mem_resp_valid_i,
    input  mem_pkg::mem_resp_t   mem_resp_i
);

    logic [cache_pkg::INDEX_W-1:0] ls_index;
    logic                          ls_we;
    logic                          ls_merge;
    logic [`CACHE_LINE_W-1:0]      ls_refill;
    logic [cache_pkg::DATA_W-1:0]  ls_st_data;
    logic [cache_pkg::MASK_W-1:0]  ls_st_mask;
    logic                          ls_st_hi;
    logic [`CACHE_LINE_W-1:0]      ls_rline;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_valid_i  (cpu_req_valid_i),
        .cpu_req_ready_o  (cpu_req_ready_o),
        .cpu_req_i        (cpu_req_i),
        .cpu_resp_valid_o (cpu_resp_valid_o),
        .cpu_resp_o       (cpu_resp_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .ls_index_o       (ls_index),
        .ls_we_o          (ls_we),
        .ls_merge_o       (ls_merge),
        .ls_refill_o      (ls_refill),
        .ls_st_data_o     (ls_st_data),
        .ls_st_mask_o     (ls_st_mask),
        .ls_st_hi_o       (ls_st_hi),
        .ls_rline_i       (ls_rline)
    );

    line_store u_store (
        .clk           (clk),
        .index_i       (ls_index),
        .we_i          (ls_we),
        .merge_i       (ls_merge),
        .refill_line_i (ls_refill),
        .st_data_i     (ls_st_data),
        .st_mask_i     (ls_st_mask),
        .st_hi_i       (ls_st_hi),
        .rline_o       (ls_rline)
    );

endmodule

// ==== src/dcache_ctrl.sv ====
// write-back data cache controller
`timescale 1ns/10ps
`include "cache_cfg.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    // CPU port
    input  logic                          cpu_req_valid_i,
    output logic                          cpu_req_ready_o,
    input  cache_pkg::cpu_req_t           cpu_req_i,
    output logic                          cpu_resp_valid_o,
    output cache_pkg::cpu_resp_t          cpu_resp_o,
    // memory port
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output mem_pkg::mem_req_t             mem_req_o,
    input  logic                          mem_resp_valid_i,
    input  mem_pkg::mem_resp_t            mem_resp_i,
    // line store
    output logic [cache_pkg::INDEX_W-1:0] ls_index_o,
    output logic                          ls_we_o,
    output logic                          ls_merge_o,
    output logic [`CACHE_LINE_W-1:0]      ls_refill_o,
    output logic [cache_pkg::DATA_W-1:0]  ls_st_data_o,
    output logic [cache_pkg::MASK_W-1:0]  ls_st_mask_o,
    output logic                          ls_st_hi_o,
    input  logic [`CACHE_LINE_W-1:0]      ls_rline_i
);

    localparam int DW = cache_pkg::DATA_W;

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_READ,
        S_MERGE,
        S_WBACK,
        S_ALLOC,
        S_FENCE
    } state_e;

    state_e state_q;

    cache_pkg::cpu_req_t  req_q;
    cache_pkg::cpu_resp_t resp_q;
    logic                 resp_valid_q;

    mem_pkg::mem_req_t    mem_req_q;
    logic                 mem_req_valid_q;
    logic                 mem_busy_q; // accepted, waiting for the response pulse

    logic [`CACHE_NLINE-1:0]     valid_q;
    logic [`CACHE_NLINE-1:0]     dirty_q;
    logic [cache_pkg::TAG_W-1:0] tag_q [`CACHE_NLINE];

    logic [cache_pkg::INDEX_W-1:0] fence_idx_q;
    logic [cache_pkg::INDEX_W-1:0] cur_idx;
    logic                          fencing;
    logic                          hit;
    logic                          line_dirty;
    logic                          fence_last;
    logic                          mem_phase;
    logic                          mem_launch;
    logic                          mem_done;
    logic                          st_hi;
    cache_pkg::addr_u              wb_addr;
    cache_pkg::addr_u              rf_addr;

    assign fencing    = (req_q.op == cache_pkg::OP_FENCE);
    assign cur_idx    = fencing ? fence_idx_q : req_q.addr.f.index;
    assign st_hi      = req_q.addr.f.offset[cache_pkg::OFFSET_W-1];
    assign hit        = valid_q[cur_idx] && (tag_q[cur_idx] == req_q.addr.f.tag);
    assign line_dirty = valid_q[cur_idx] && dirty_q[cur_idx];
    assign fence_last = (fence_idx_q == cache_pkg::INDEX_W'(`CACHE_NLINE - 1));

    assign mem_phase  = (state_q == S_WBACK) || (state_q == S_ALLOC);
    assign mem_launch = mem_phase && !mem_req_valid_q && !mem_busy_q;
    assign mem_done   = mem_busy_q && mem_resp_valid_i;

    // victim address from the stored tag
    always_comb begin
        wb_addr.f.tag    = tag_q[cur_idx];
        wb_addr.f.index  = cur_idx;
        wb_addr.f.offset = '0;
    end

    always_comb begin
        rf_addr          = req_q.addr;
        rf_addr.f.offset = '0;
    end

    assign cpu_req_ready_o  = (state_q == S_IDLE);
    assign cpu_resp_valid_o = resp_valid_q;
    assign cpu_resp_o       = resp_q;
    assign mem_req_valid_o  = mem_req_valid_q;
    assign mem_req_o        = mem_req_q;

    assign ls_index_o   = cur_idx;
    assign ls_we_o      = (state_q == S_MERGE) || ((state_q == S_ALLOC) && mem_done);
    assign ls_merge_o   = (state_q == S_MERGE);
    assign ls_refill_o  = mem_resp_i.rline; // written in the response cycle
    assign ls_st_data_o = req_q.wdata;
    assign ls_st_mask_o = req_q.wmask;
    assign ls_st_hi_o   = st_hi;

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cpu_req_valid_i) begin
            req_q <= cpu_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= S_IDLE;
            valid_q      <= '0;
            dirty_q      <= '0;
            fence_idx_q  <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (cpu_req_valid_i) begin
                        fence_idx_q <= '0;
                        if (cpu_req_i.op == cache_pkg::OP_FENCE) begin
                            state_q <= S_FENCE;
                        end else begin
                            state_q <= S_COMPARE;
                        end
                    end
                end
                S_COMPARE: begin
                    if (hit) begin
                        state_q <= S_READ;
                    end else if (line_dirty) begin
                        state_q <= S_WBACK; // evict first
                    end else begin
                        state_q <= S_ALLOC;
                    end
                end
                S_READ: begin
                    if (req_q.op == cache_pkg::OP_STORE) begin
                        state_q <= S_MERGE;
                    end else begin
                        resp_valid_q <= 1'b1;
                        state_q      <= S_IDLE;
                    end
                end
                S_MERGE: begin
                    dirty_q[cur_idx] <= 1'b1;
                    resp_valid_q     <= 1'b1;
                    state_q          <= S_IDLE;
                end
                S_WBACK: begin
                    if (mem_done && !fencing) begin
                        state_q <= S_ALLOC;
                    end else if (mem_done) begin
                        dirty_q[cur_idx] <= 1'b0;
                        if (fence_last) begin
                            resp_valid_q <= 1'b1;
                            state_q      <= S_IDLE;
                        end else begin
                            fence_idx_q <= fence_idx_q + 1'b1;
                            state_q     <= S_FENCE;
                        end
                    end
                end
                S_ALLOC: begin
                    if (mem_done) begin
                        valid_q[cur_idx] <= 1'b1;
                        dirty_q[cur_idx] <= 1'b0;
                        state_q          <= S_COMPARE; // retry, now a hit
                    end
                end
                S_FENCE: begin
                    if (line_dirty) begin
                        state_q <= S_WBACK;
                    end else if (fence_last) begin
                        resp_valid_q <= 1'b1;
                        state_q      <= S_IDLE;
                    end else begin
                        fence_idx_q <= fence_idx_q + 1'b1; // clean line skipped
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_ALLOC && mem_done) begin
            tag_q[cur_idx] <= req_q.addr.f.tag;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        resp_q.op <= req_q.op;
        if (state_q == S_READ) begin
            if (req_q.op == cache_pkg::OP_LOAD) begin
                resp_q.rdata <= st_hi ? ls_rline_i[2*DW-1:DW] : ls_rline_i[DW-1:0];
            end else begin
                resp_q.rdata <= '0;
            end
        end else if (state_q == S_FENCE) begin
            resp_q.rdata <= '0;
        end
    end

    // memory request handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_valid_q <= 1'b0;
            mem_busy_q      <= 1'b0;
        end else if (mem_req_valid_q && mem_req_ready_i) begin
            mem_req_valid_q <= 1'b0;
            mem_busy_q      <= 1'b1;
        end else if (mem_done) begin
            mem_busy_q <= 1'b0;
        end else if (mem_launch) begin
            mem_req_valid_q <= 1'b1;
        end
    end

    // payload frozen until accepted
    always_ff @(posedge clk) begin
        if (mem_launch) begin
            mem_req_q.write <= (state_q == S_WBACK);
            mem_req_q.addr  <= (state_q == S_WBACK) ? wb_addr.raw : rf_addr.raw;
            mem_req_q.wline <= ls_rline_i;
        end
    end

endmodule

// ==== src/line_store.sv ====
// banked line store with store merge
`timescale 1ns/10ps
`include "cache_cfg.svh"

module line_store (
    input  logic                             clk,
    input  logic [cache_pkg::INDEX_W-1:0]    index_i,
    input  logic                             we_i,
    input  logic                             merge_i,
    input  logic [`CACHE_LINE_W-1:0]         refill_line_i,
    input  logic [cache_pkg::DATA_W-1:0]     st_data_i,
    input  logic [cache_pkg::MASK_W-1:0]     st_mask_i,
    input  logic                             st_hi_i,
    output logic [`CACHE_LINE_W-1:0]         rline_o
);

    localparam int BANK_W = $clog2(`CACHE_NBANK);
    localparam int ROW_W  = cache_pkg::INDEX_W - BANK_W;
    localparam int NBYTE  = `CACHE_LINE_W / 8;

    logic [`CACHE_LINE_W-1:0] bank_rdata [`CACHE_NBANK];
    logic [BANK_W-1:0]        bank_sel;
    logic [BANK_W-1:0]        bank_q;
    logic [NBYTE-1:0]         byte_en;
    logic [`CACHE_LINE_W-1:0] bit_en;
    logic [`CACHE_LINE_W-1:0] wline;

    assign bank_sel = index_i[cache_pkg::INDEX_W-1 -: BANK_W];

    // read data lags the address by one cycle
    always_ff @(posedge clk) begin
        bank_q <= bank_sel;
    end

    assign rline_o = bank_rdata[bank_q];

    // byte mask lands in the upper or lower doubleword
    always_comb begin
        if (st_hi_i) begin
            byte_en = {st_mask_i, {cache_pkg::MASK_W{1'b0}}};
        end else begin
            byte_en = {{cache_pkg::MASK_W{1'b0}}, st_mask_i};
        end
        for (int i = 0; i < NBYTE; i++) begin
            bit_en[i*8 +: 8] = {8{byte_en[i]}};
        end
    end

    assign wline = merge_i ? (({2{st_data_i}} & bit_en) | (rline_o & ~bit_en))
                           : refill_line_i;

    for (genvar b = 0; b < `CACHE_NBANK; b++) begin : g_bank
        line_sram u_bank (
            .clk     (clk),
            .cen_i   (bank_sel != BANK_W'(b)), // only the addressed bank
            .wen_i   (~(we_i && (bank_sel == BANK_W'(b)))),
            .addr_i  (index_i[ROW_W-1:0]),
            .wdata_i (wline),
            .rdata_o (bank_rdata[b])
        );
    end

endmodule

// ==== src/line_sram.sv ====
// single port line SRAM
`timescale 1ns/10ps
`include "cache_cfg.svh"

module line_sram #(
    parameter int DEPTH = `CACHE_NLINE / `CACHE_NBANK,
    parameter int WIDTH = `CACHE_LINE_W
) (
    input  logic                     clk,
    input  logic                     cen_i,  // active low
    input  logic                     wen_i,  // active low
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!cen_i && !wen_i) begin
            mem[addr_i] <= wdata_i;
        end else if (!cen_i) begin
            rdata_o <= mem[addr_i]; // rdata held on writes and when disabled
        end
    end

endmodule

// ==== src/mem_pkg.sv ====
// memory side line transfer types
`include "cache_cfg.svh"

package mem_pkg;

    // one line read or write toward memory
    typedef struct packed {
        logic                     write;
        logic [`CACHE_ADDR_W-1:0] addr;  // line aligned
        logic [`CACHE_LINE_W-1:0] wline; // ignored on reads
    } mem_req_t;

    // response pulse payload
    typedef struct packed {
        logic [`CACHE_LINE_W-1:0] rline; // only valid for reads
    } mem_resp_t;

endpackage

// ==== src/cache_pkg.sv ====
// CPU side cache types
`include "cache_cfg.svh"

package cache_pkg;

    localparam int DATA_W   = 64; // one doubleword
    localparam int MASK_W   = DATA_W / 8;
    localparam int INDEX_W  = $clog2(`CACHE_NLINE);
    localparam int OFFSET_W = $clog2(`CACHE_LINE_W / 8);
    localparam int TAG_W    = `CACHE_ADDR_W - INDEX_W - OFFSET_W;

    // address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset; // bit 3 picks the doubleword
    } addr_fields_t;

    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        addr_fields_t             f;
    } addr_u;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FENCE = 2'd2
    } cpu_op_e;

    typedef struct packed {
        cpu_op_e             op;
        addr_u               addr;
        logic [DATA_W-1:0]   wdata;
        logic [MASK_W-1:0]   wmask; // byte enables for stores
    } cpu_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata; // load data, zero otherwise
        cpu_op_e           op;
    } cpu_resp_t;

endpackage

// ==== src/cache_cfg.svh ====
// data cache sizing
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// number of cache lines, direct mapped
`define CACHE_NLINE 256

// line SRAM banks, each holds CACHE_NLINE / CACHE_NBANK lines
`define CACHE_NBANK 4

`define CACHE_LINE_W 128 // bits per line, two doublewords

// CPU and memory address width
`define CACHE_ADDR_W 64

`endif
